/* src/ctrl_defines.svh */
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// ring geometry
`define CTX_NUM 4
`define PHASE_W 2

// datapath widths
`define ADDR_W 10
`define CNT_W 6
`define SIZE_W 32

// low bit of each context's iteration field in size_i
`define SIZE_LSB_0 0
`define SIZE_LSB_1 8
`define SIZE_LSB_2 16
`define SIZE_LSB_3 24

// output buffer blocks, 8 words each
`define OB_BASE_0 10'h000
`define OB_BASE_1 10'h008
`define OB_BASE_2 10'h010
`define OB_BASE_3 10'h018

// weight buffer blocks, 64 words each
`define WB_BASE_0 10'h000
`define WB_BASE_1 10'h040
`define WB_BASE_2 10'h080
`define WB_BASE_3 10'h0c0

// sweep limits
`define ML_LAST 63
`define EX_FROM 15

// last write-back step
`define OUT_LAST 7

`endif

/* src/ctrl_pkg.sv */
`default_nettype none

`include "ctrl_defines.svh"

package ctrl_pkg;

    // per-context job state
    typedef enum logic [2:0] {
        CTX_IDLE,
        CTX_START,
        CTX_CLEAR,
        CTX_ML,
        CTX_UPDATE,
        CTX_OUT,
        CTX_VALID
    } ctx_state_e;

    // slot index, counts down
    typedef logic [`PHASE_W-1:0] phase_t;

    // one context record as it circulates in the ring
    typedef struct packed {
        ctx_state_e          state;
        logic [`CNT_W-1:0]   iter;
        logic [`CNT_W-1:0]   cnt;
        logic [`ADDR_W-1:0]  ib_addr;
        logic [`ADDR_W-1:0]  ob_addr;
        logic                ob_wr;
        phase_t              ib_sel;
        logic [`ADDR_W-1:0]  wb_waddr;
        logic [`ADDR_W-1:0]  wb_raddr;
        logic                wb_wr;
        logic                wb_sel;
        logic [`ADDR_W-1:0]  kb_raddr;
        logic                ex_sel;
        logic [2:0]          ml_sel;
        logic                update;
        logic                ml_clr;
    } ctx_slot_t;

endpackage

`default_nettype wire

/* src/phase_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defines.svh"

module phase_sequencer (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    input  wire logic [`CTX_NUM-1:0]     start_i,
    input  wire logic [`SIZE_W-1:0]      size_i,
    input  wire ctrl_pkg::ctx_state_e    new_state_i,
    output ctrl_pkg::phase_t             phase_o,
    output logic                         start_sel_o,
    output logic [`CNT_W-1:0]            iter_init_o,
    output logic [`CTX_NUM-1:0]          valid_o
);

    import ctrl_pkg::*;

    localparam int SIZE_LSB [`CTX_NUM] = '{
        `SIZE_LSB_0,
        `SIZE_LSB_1,
        `SIZE_LSB_2,
        `SIZE_LSB_3
    };

    phase_t              phase_q;
    logic [`CTX_NUM-1:0] valid_q;

    // phase names the context leaving the last ring stage
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            phase_q <= phase_t'(`CTX_NUM - 1);
        end else begin
            phase_q <= phase_q - 1'b1;
        end
    end

    assign start_sel_o = start_i[phase_q];
    assign iter_init_o = size_i[SIZE_LSB[phase_q] +: `CNT_W];

    // valid follows the state written back for this phase
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (new_state_i == CTX_VALID) begin
            valid_q[phase_q] <= 1'b1;
        end else if (new_state_i == CTX_IDLE) begin
            valid_q[phase_q] <= 1'b0;
        end
    end

    assign phase_o = phase_q;
    assign valid_o = valid_q;

    // ring rotation depends on a strict countdown
    a_phase_step: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $past(rst_ni) |-> phase_q == phase_t'($past(phase_q) - 1'b1)
    ) else $error("phase did not step down by one");

endmodule

`default_nettype wire

/* src/context_step.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defines.svh"

module context_step (
    input  wire ctrl_pkg::phase_t        phase_i,
    input  wire logic                    start_sel_i,
    input  wire logic [`CNT_W-1:0]       iter_init_i,
    input  wire ctrl_pkg::ctx_slot_t     slot_i,
    output ctrl_pkg::ctx_slot_t          slot_o
);

    import ctrl_pkg::*;

    // bump the in-block offset, keep the block
    function automatic logic [`ADDR_W-1:0] inc_low(input logic [`ADDR_W-1:0] addr);
        return {addr[`ADDR_W-1:`CNT_W], addr[`CNT_W-1:0] + 1'b1};
    endfunction

    // common advance of a clear or sweep step
    function automatic ctx_slot_t sweep_step(input ctx_slot_t s);
        ctx_slot_t r;
        r          = s;
        r.wb_waddr = inc_low(s.wb_waddr);
        r.wb_raddr = inc_low(s.wb_raddr);
        r.kb_raddr = inc_low(s.kb_raddr);
        r.cnt      = s.cnt + 1'b1;
        r.wb_wr    = 1'b1;
        return r;
    endfunction

    always_comb begin
        slot_o        = slot_i;
        slot_o.ob_wr  = 1'b0;
        slot_o.wb_wr  = 1'b0;
        slot_o.wb_sel = 1'b0;
        slot_o.ex_sel = 1'b0;
        slot_o.ml_sel = '0;
        slot_o.update = 1'b0;
        slot_o.ml_clr = 1'b0;

        unique case (slot_i.state)
            CTX_IDLE: begin
                slot_o.iter     = iter_init_i;
                slot_o.cnt      = '0;
                slot_o.ib_addr  = '0;
                slot_o.ib_sel   = phase_i;
                slot_o.ob_addr  = {slot_i.ob_addr[`ADDR_W-1:3], 3'b000};
                slot_o.wb_waddr = {slot_i.wb_waddr[`ADDR_W-1:`CNT_W], {`CNT_W{1'b0}}};
                slot_o.wb_raddr = {slot_i.wb_raddr[`ADDR_W-1:`CNT_W], {`CNT_W{1'b0}}};
                slot_o.kb_raddr = '0;
                slot_o.state    = start_sel_i ? CTX_START : CTX_IDLE;
            end

            CTX_START: begin
                // reads start one behind so the first sweep step lands on word 0
                slot_o.wb_waddr = {slot_i.wb_waddr[`ADDR_W-1:`CNT_W], {`CNT_W{1'b0}}};
                slot_o.wb_raddr = {slot_i.wb_raddr[`ADDR_W-1:`CNT_W], {`CNT_W{1'b1}}};
                slot_o.kb_raddr = {slot_i.kb_raddr[`ADDR_W-1:`CNT_W], {`CNT_W{1'b1}}};
                slot_o.wb_wr    = 1'b1;
                slot_o.ml_clr   = 1'b1;
                slot_o.state    = CTX_CLEAR;
            end

            CTX_CLEAR: begin
                slot_o         = sweep_step(slot_o);
                slot_o.ib_addr = slot_i.ib_addr + 1'b1;
                slot_o.ml_clr  = 1'b1;
                slot_o.state   = CTX_ML;
            end

            CTX_ML: begin
                slot_o = sweep_step(slot_o);
                // tail of the sweep takes the external operand
                if (slot_i.cnt >= `EX_FROM && slot_i.cnt != `ML_LAST) begin
                    slot_o.ex_sel = 1'b1;
                    slot_o.wb_sel = 1'b1;
                end else begin
                    slot_o.ib_addr = slot_i.ib_addr + 1'b1;
                end
                if (slot_i.cnt == `ML_LAST) begin
                    slot_o.state = (slot_i.iter == '0) ? CTX_OUT : CTX_UPDATE;
                end else begin
                    slot_o.state = CTX_ML;
                end
            end

            CTX_UPDATE: begin
                slot_o         = sweep_step(slot_o);
                slot_o.ib_addr = slot_i.ib_addr + 1'b1;
                slot_o.iter    = slot_i.iter - 1'b1;
                slot_o.update  = 1'b1;
                slot_o.state   = CTX_ML;
            end

            CTX_OUT: begin
                slot_o.ob_wr   = 1'b1;
                slot_o.ob_addr = {slot_i.ob_addr[`ADDR_W-1:3], slot_i.cnt[2:0]};
                slot_o.ml_sel  = slot_i.cnt[2:0];
                slot_o.update  = (slot_i.cnt == '0);
                slot_o.cnt     = slot_i.cnt + 1'b1;
                slot_o.state   = (slot_i.cnt == `OUT_LAST) ? CTX_VALID : CTX_OUT;
            end

            CTX_VALID: begin
                // held until the host drops start
                slot_o.state = start_sel_i ? CTX_VALID : CTX_IDLE;
            end

            default: begin
                slot_o.state = CTX_IDLE;
            end
        endcase
    end

    // a slot coming back with a write has just left write-back
    always_comb begin
        if (slot_i.ob_wr) begin
            a_ob_wr_in_out: assert (slot_i.state inside {CTX_OUT, CTX_VALID})
                else $error("output write outside write-back");
        end
    end

endmodule

`default_nettype wire

/* src/context_ring.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defines.svh"

module context_ring (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire ctrl_pkg::ctx_slot_t   slot_i,
    output ctrl_pkg::ctx_slot_t        slot_o,
    output logic [`ADDR_W-1:0]         ib_raddr_o,
    output ctrl_pkg::phase_t           ib_sel_o,
    output logic [`ADDR_W-1:0]         ob_addr_o,
    output logic                       ob_wr_o,
    output logic [`ADDR_W-1:0]         wb_waddr_o,
    output logic [`ADDR_W-1:0]         wb_raddr_o,
    output logic                       wb_wr_o,
    output logic                       wb_sel_o,
    output logic [`ADDR_W-1:0]         kb_raddr_o,
    output logic                       ex_sel_o,
    output logic [2:0]                 ml_sel_o,
    output logic                       update_o,
    output logic                       ml_clr_o
);

    import ctrl_pkg::*;

    localparam logic [`ADDR_W-1:0] OB_BASE [`CTX_NUM] = '{
        `OB_BASE_0,
        `OB_BASE_1,
        `OB_BASE_2,
        `OB_BASE_3
    };

    localparam logic [`ADDR_W-1:0] WB_BASE [`CTX_NUM] = '{
        `WB_BASE_0,
        `WB_BASE_1,
        `WB_BASE_2,
        `WB_BASE_3
    };

    ctx_slot_t slot_q [`CTX_NUM];

    // idle record of context k, holding its buffer blocks
    function automatic ctx_slot_t reset_slot(input int k);
        ctx_slot_t s;
        s          = '0;
        s.state    = CTX_IDLE;
        s.ob_addr  = OB_BASE[k];
        s.wb_waddr = WB_BASE[k];
        s.wb_raddr = WB_BASE[k];
        return s;
    endfunction

    // stage k holds context k out of reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int k = 0; k < `CTX_NUM; k++) begin
                slot_q[k] <= reset_slot(k);
            end
        end else begin
            slot_q[0] <= slot_i;
            for (int k = 1; k < `CTX_NUM; k++) begin
                slot_q[k] <= slot_q[k-1];
            end
        end
    end

    assign slot_o = slot_q[`CTX_NUM-1];

    // read addresses leave at stage 0
    assign ib_raddr_o = slot_q[0].ib_addr;
    assign wb_raddr_o = slot_q[0].wb_raddr;
    assign kb_raddr_o = slot_q[0].kb_raddr;

    // one cycle later, operand selects and weight write
    assign ib_sel_o   = slot_q[1].ib_sel;
    assign wb_waddr_o = slot_q[1].wb_waddr;
    assign wb_wr_o    = slot_q[1].wb_wr;
    assign wb_sel_o   = slot_q[1].wb_sel;
    assign ex_sel_o   = slot_q[1].ex_sel;
    assign update_o   = slot_q[1].update;
    assign ml_clr_o   = slot_q[1].ml_clr;

    // write-back at stage 2
    assign ob_addr_o  = slot_q[2].ob_addr;
    assign ob_wr_o    = slot_q[2].ob_wr;
    assign ml_sel_o   = slot_q[2].ml_sel;

    // a context never writes weights and outputs in the same step
    a_wr_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(slot_q[0].ob_wr && slot_q[0].wb_wr)
    ) else $error("output and weight write in one slot");

endmodule

`default_nettype wire

/* src/barrel_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defines.svh"

module barrel_controller (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic [`CTX_NUM-1:0]   start_i,
    input  wire logic [`SIZE_W-1:0]    size_i,
    output logic [`CTX_NUM-1:0]        valid_o,
    output logic [`ADDR_W-1:0]         ib_raddr_o,
    output ctrl_pkg::phase_t           ib_sel_o,
    output logic [`ADDR_W-1:0]         ob_addr_o,
    output logic                       ob_wr_o,
    output logic [`ADDR_W-1:0]         wb_waddr_o,
    output logic [`ADDR_W-1:0]         wb_raddr_o,
    output logic                       wb_wr_o,
    output logic                       wb_sel_o,
    output logic [`ADDR_W-1:0]         kb_raddr_o,
    output logic                       ex_sel_o,
    output logic [2:0]                 ml_sel_o,
    output logic                       update_o,
    output logic                       ml_clr_o
);

    import ctrl_pkg::*;

    phase_t            phase;
    logic              start_sel;
    logic [`CNT_W-1:0] iter_init;
    ctx_slot_t         ring_out;
    ctx_slot_t         step_out;

    phase_sequencer u_phase_sequencer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (start_i),
        .size_i      (size_i),
        .new_state_i (step_out.state),
        .phase_o     (phase),
        .start_sel_o (start_sel),
        .iter_init_o (iter_init),
        .valid_o     (valid_o)
    );

    // shared next-state logic for all contexts
    context_step u_context_step (
        .phase_i     (phase),
        .start_sel_i (start_sel),
        .iter_init_i (iter_init),
        .slot_i      (ring_out),
        .slot_o      (step_out)
    );

    context_ring u_context_ring (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .slot_i     (step_out),
        .slot_o     (ring_out),
        .ib_raddr_o (ib_raddr_o),
        .ib_sel_o   (ib_sel_o),
        .ob_addr_o  (ob_addr_o),
        .ob_wr_o    (ob_wr_o),
        .wb_waddr_o (wb_waddr_o),
        .wb_raddr_o (wb_raddr_o),
        .wb_wr_o    (wb_wr_o),
        .wb_sel_o   (wb_sel_o),
        .kb_raddr_o (kb_raddr_o),
        .ex_sel_o   (ex_sel_o),
        .ml_sel_o   (ml_sel_o),
        .update_o   (update_o),
        .ml_clr_o   (ml_clr_o)
    );

endmodule

`default_nettype wire

/* tests/tb_barrel_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defines.svh"

module tb_barrel_controller;

    import ctrl_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 16;

    // job length in cycles for iteration fields 0 and 3
    localparam int JOB_0 = 4 * 73;
    localparam int JOB_3 = 4 * (64 * 3 + 73);
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 40 + 3 * JOB_0 + 2 * JOB_3 + 1000;

    // external operand steps per sweep
    localparam int EX_STEPS = `ML_LAST - `EX_FROM;

    localparam logic [`ADDR_W-1:0] OB_BASE [`CTX_NUM] = '{
        `OB_BASE_0,
        `OB_BASE_1,
        `OB_BASE_2,
        `OB_BASE_3
    };

    localparam logic [`ADDR_W-1:0] WB_BASE [`CTX_NUM] = '{
        `WB_BASE_0,
        `WB_BASE_1,
        `WB_BASE_2,
        `WB_BASE_3
    };

    localparam int SIZE_LSB [`CTX_NUM] = '{
        `SIZE_LSB_0,
        `SIZE_LSB_1,
        `SIZE_LSB_2,
        `SIZE_LSB_3
    };

    logic                clk_i;
    logic                rst_ni;
    logic [`CTX_NUM-1:0] start_i;
    logic [`SIZE_W-1:0]  size_i;
    logic [`CTX_NUM-1:0] valid_o;
    logic [`ADDR_W-1:0]  ib_raddr_o;
    phase_t              ib_sel_o;
    logic [`ADDR_W-1:0]  ob_addr_o;
    logic                ob_wr_o;
    logic [`ADDR_W-1:0]  wb_waddr_o;
    logic [`ADDR_W-1:0]  wb_raddr_o;
    logic                wb_wr_o;
    logic                wb_sel_o;
    logic [`ADDR_W-1:0]  kb_raddr_o;
    logic                ex_sel_o;
    logic [2:0]          ml_sel_o;
    logic                update_o;
    logic                ml_clr_o;

    int     errors;
    int     seed;
    string  test_name;
    phase_t tb_phase;
    phase_t wr_ctx;
    phase_t upd_ctx;
    int     wr_count [`CTX_NUM];
    int     upd_count [`CTX_NUM];
    int     ex_count [`CTX_NUM];

    barrel_controller i_dut (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .start_i    (start_i),
        .size_i     (size_i),
        .valid_o    (valid_o),
        .ib_raddr_o (ib_raddr_o),
        .ib_sel_o   (ib_sel_o),
        .ob_addr_o  (ob_addr_o),
        .ob_wr_o    (ob_wr_o),
        .wb_waddr_o (wb_waddr_o),
        .wb_raddr_o (wb_raddr_o),
        .wb_wr_o    (wb_wr_o),
        .wb_sel_o   (wb_sel_o),
        .kb_raddr_o (kb_raddr_o),
        .ex_sel_o   (ex_sel_o),
        .ml_sel_o   (ml_sel_o),
        .update_o   (update_o),
        .ml_clr_o   (ml_clr_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // reference countdown, context c leaves the last stage at phase c
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tb_phase <= 2'd3;
        end else begin
            tb_phase <= tb_phase - 1'b1;
        end
    end

    // stage 2 and stage 1 hold the contexts one and two behind
    assign wr_ctx  = tb_phase - 2'd1;
    assign upd_ctx = tb_phase - 2'd2;

    task automatic check_equal(input string what, input int expected, input int actual);
        if (expected != actual) begin
            errors++;
            $display("** Error [%s] %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic abort_run(input string reason);
        errors++;
        $display("[%s] %s", test_name, reason);
        $display("Test failures found");
        $fatal(1, "run aborted");
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (rst_ni && ob_wr_o) begin
            check_equal("write address",
                        int'(OB_BASE[wr_ctx]) + wr_count[wr_ctx] % 8, int'(ob_addr_o));
            check_equal("lane select", wr_count[wr_ctx] % 8, int'(ml_sel_o));
            wr_count[wr_ctx]++;
        end
        if (rst_ni && wb_wr_o) begin
            check_equal("input select", int'(upd_ctx), int'(ib_sel_o));
            check_equal("weight write block", int'(WB_BASE[upd_ctx] >> `CNT_W),
                        int'(wb_waddr_o >> `CNT_W));
        end
        if (rst_ni && ex_sel_o) begin
            ex_count[upd_ctx]++;
        end
        if (rst_ni && update_o) begin
            upd_count[upd_ctx]++;
        end
    end

    task automatic step_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // last write shows two stages after valid, sampled at the falling edge
    task automatic drain_write_back();
        repeat (3) step_cycle();
    endtask

    task automatic clear_counts();
        for (int c = 0; c < `CTX_NUM; c++) begin
            wr_count[c] = 0;
            upd_count[c] = 0;
            ex_count[c] = 0;
        end
    endtask

    task automatic wait_valid(input int ctx, input int limit, output int cycles);
        cycles = 0;
        while (valid_o[ctx] !== 1'b1) begin
            if (cycles >= limit) begin
                abort_run($sformatf("valid bit %0d did not rise within %0d cycles", ctx, limit));
            end else begin
                step_cycle();
                cycles++;
            end
        end
    endtask

    // drop start and wait for the next idle visit to clear valid
    task automatic finish_job(input int ctx);
        int cycles;
        start_i[ctx] = 1'b0;
        cycles = 0;
        while (valid_o[ctx] !== 1'b0) begin
            if (cycles >= 8) begin
                abort_run($sformatf("valid bit %0d still set 8 cycles after start dropped", ctx));
            end else begin
                step_cycle();
                cycles++;
            end
        end
    endtask

    // start a job and check its length against 64n + 73 steps
    task automatic run_timed_job(input int ctx, input int n);
        int     cycles;
        int     expected;
        phase_t align;
        align = tb_phase - phase_t'(ctx);
        expected = 4 * (64 * n + 73) + int'(align) + 1;
        start_i[ctx] = 1'b1;
        wait_valid(ctx, JOB_3 + 8, cycles);
        check_equal("job length in cycles", expected, cycles);
        drain_write_back();
    endtask

    task automatic test_idle_after_reset();
        test_name = "idle_after_reset";
        for (int i = 0; i < 40; i++) begin
            check_equal("valid bits", 0, int'(valid_o));
            check_equal("write, update and clear", 0,
                        int'({ob_wr_o, wb_wr_o, update_o, ml_clr_o}));
            step_cycle();
        end
    endtask

    task automatic test_single_job();
        test_name = "single_job";
        size_i = '0;
        clear_counts();
        run_timed_job(0, 0);
        check_equal("valid bits", 1, int'(valid_o));
        check_equal("output writes", 8, wr_count[0]);
        check_equal("update pulses", 1, upd_count[0]);
        check_equal("external operand steps", EX_STEPS, ex_count[0]);
        finish_job(0);
    endtask

    task automatic test_iteration_count();
        int n;
        test_name = "iteration_count";
        n = 1 + int'($unsigned($random(seed)) % 3);
        size_i = '0;
        size_i[`SIZE_LSB_2 +: `CNT_W] = `CNT_W'(n);
        clear_counts();
        run_timed_job(2, n);
        check_equal("update pulses", n + 1, upd_count[2]);
        check_equal("output writes", 8, wr_count[2]);
        check_equal("external operand steps", EX_STEPS * (n + 1), ex_count[2]);
        finish_job(2);
    endtask

    task automatic test_all_contexts();
        int cycles;
        test_name = "all_contexts";
        size_i = '0;
        for (int c = 0; c < `CTX_NUM; c++) begin
            size_i[SIZE_LSB[c] +: `CNT_W] = `CNT_W'(3 - c);
        end
        clear_counts();
        start_i = '1;
        for (int c = 0; c < `CTX_NUM; c++) begin
            wait_valid(c, JOB_3 + 8, cycles);
        end
        drain_write_back();
        for (int c = 0; c < `CTX_NUM; c++) begin
            check_equal($sformatf("writes of context %0d", c), 8, wr_count[c]);
            check_equal($sformatf("updates of context %0d", c), 4 - c, upd_count[c]);
            check_equal($sformatf("external steps of context %0d", c),
                        EX_STEPS * (4 - c), ex_count[c]);
        end
        for (int c = 0; c < `CTX_NUM; c++) begin
            finish_job(c);
        end
    endtask

    task automatic test_handshake();
        int cycles;
        test_name = "handshake";
        size_i = '0;
        clear_counts();
        start_i[1] = 1'b1;
        wait_valid(1, JOB_0 + 8, cycles);
        for (int i = 0; i < 20; i++) begin
            step_cycle();
            check_equal("valid held while start high", 1, int'(valid_o[1]));
        end
        finish_job(1);
        // restart gives a second full write-back
        clear_counts();
        start_i[1] = 1'b1;
        wait_valid(1, JOB_0 + 8, cycles);
        drain_write_back();
        check_equal("writes after restart", 8, wr_count[1]);
        finish_job(1);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed = 32'h9b57;
        errors = 0;
        test_name = "reset";
        start_i = '0;
        size_i = '0;
        rst_ni = 1'b0;
        clear_counts();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        test_idle_after_reset();
        test_single_job();
        test_iteration_count();
        test_all_contexts();
        test_handshake();

        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/ctrl_pkg.sv
src/phase_sequencer.sv
src/context_step.sv
src/context_ring.sv
src/barrel_controller.sv
tests/tb_barrel_controller.sv

/* Makefile */
# Verilator flow for the barrel controller

VERILATOR ?= verilator
FILELIST  ?= all.f
RTL_TOP   ?= barrel_controller
TB_TOP    ?= tb_barrel_controller
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= All tests passed!

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)

# the run passes only if the pass message shows up in the output
sim: build
	@out="$$($(BUILD_DIR)/$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
